// File: hw/board_glue_pkg.sv
package board_glue_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int color_w     = 8;
    localparam int ctrl_word_w = 32;  // host control word and controls word
    localparam int ir_code_w   = 16;
    localparam int ir_cnt_w    = 8;
    localparam int osd_color_w = 2;

    // bit positions inside the host control word
    localparam int ctrl_bit_hsync_pol  = 8;
    localparam int ctrl_bit_vsync_pol  = 9;
    localparam int ctrl_bit_vsync_type = 10;
    localparam int ctrl_bit_tp_en      = 12;
    localparam int ctrl_bit_csc_en     = 13;
    localparam int ctrl_bit_framelock  = 14;
    localparam int ctrl_bit_vip_select = 15;  // misc word bit, mapped here

    // ============================================================
    // grouped signals
    // ============================================================
    typedef struct packed {
        logic [color_w-1:0] r;
        logic [color_w-1:0] g;
        logic [color_w-1:0] b;
    } pixel_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vid_sync_t;

    typedef struct packed {
        logic                   enable;
        logic [osd_color_w-1:0] color;
    } osd_req_t;

    // decoded subset of the host control word
    typedef struct packed {
        logic vip_select;
        logic framelock;
        logic csc_en;
        logic testpattern_en;
        logic vsync_type;
        logic vsync_pol;
        logic hsync_pol;
    } ctrl_fields_t;

    // ============================================================
    // osd palette, index = color code
    // ============================================================
    localparam pixel_t osd_black  = 24'h000000;
    localparam pixel_t osd_blue   = 24'h0000ff;
    localparam pixel_t osd_yellow = 24'hffff00;
    localparam pixel_t osd_white  = 24'hffffff;

endpackage

// File: hw/sys_ctrl_decode.sv
`timescale 1ns/10ps

module sys_ctrl_decode (
    input  logic                                   clk27,
    input  logic                                   sys_reset_n,
    input  logic [board_glue_pkg::ctrl_word_w-1:0] sys_ctrl_i,
    input  logic [board_glue_pkg::ir_code_w-1:0]   ir_code_i,
    input  logic                                   vsync_i,      // polarity corrected
    input  logic                                   resync_led_i,
    output board_glue_pkg::ctrl_fields_t           fields_o,
    output logic                                   vs_flag_o,
    output logic [7:0]                             led_o
);

    logic ir_code_zero;

    // one register stage on the host word
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            fields_o <= '0;
        end else begin
            fields_o.hsync_pol      <= sys_ctrl_i[board_glue_pkg::ctrl_bit_hsync_pol];
            fields_o.vsync_pol      <= sys_ctrl_i[board_glue_pkg::ctrl_bit_vsync_pol];
            fields_o.vsync_type     <= sys_ctrl_i[board_glue_pkg::ctrl_bit_vsync_type];
            fields_o.testpattern_en <= sys_ctrl_i[board_glue_pkg::ctrl_bit_tp_en];
            fields_o.csc_en         <= sys_ctrl_i[board_glue_pkg::ctrl_bit_csc_en];
            fields_o.framelock      <= sys_ctrl_i[board_glue_pkg::ctrl_bit_framelock];
            fields_o.vip_select     <= sys_ctrl_i[board_glue_pkg::ctrl_bit_vip_select];
        end
    end

    // polled by host and held low while test pattern runs
    assign vs_flag_o = ~vsync_i & ~fields_o.testpattern_en;

    assign ir_code_zero = (ir_code_i == '0);

    // led 7 ir idle, led 1 resync, led 0 framelock
    assign led_o = {
        ir_code_zero,
        5'b00000,
        resync_led_i,
        fields_o.framelock
    };

    // led 0 shows the framelock bit one cycle after the host writes it
    a_led_framelock_delay: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        $past(sys_reset_n) |->
            led_o[0] == $past(sys_ctrl_i[board_glue_pkg::ctrl_bit_framelock])
    );

endmodule

// File: hw/digitizer_sync.sv
`timescale 1ns/10ps

module digitizer_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                                   clk27,
    input  logic                                   sys_reset_n,
    input  logic                                   isl_hsync_i,
    input  logic                                   isl_vsync_i,
    input  logic                                   isl_fid_i,
    input  logic [1:0]                             key_i,        // active low
    input  logic [board_glue_pkg::ir_code_w-1:0]   ir_code_i,
    input  logic [board_glue_pkg::ir_cnt_w-1:0]    ir_code_cnt_i,
    input  logic                                   hsync_pol_i,
    input  logic                                   vsync_pol_i,
    output logic                                   hsync_o,
    output logic                                   vsync_o,
    output logic                                   fid_o,
    output logic [board_glue_pkg::ctrl_word_w-1:0] controls_o
);

    logic [SYNC_STAGES-1:0][4:0] sync_q;    // {hsync, vsync, fid, key1, key0}
    logic [4:0]                  sync_out;
    logic [5:0]                  key_bits;

    // ============================================================
    // synchronizer chains sharing one shift structure
    // ============================================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            sync_q <= '1;  // keys read as released
        end else begin
            sync_q[0] <= {isl_hsync_i, isl_vsync_i, isl_fid_i, key_i};
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign sync_out = sync_q[SYNC_STAGES-1];

    // polarity bit 1 means the digitizer drives active-high syncs
    assign hsync_o = sync_out[4] ^ hsync_pol_i;
    assign vsync_o = sync_out[3] ^ vsync_pol_i;
    assign fid_o   = sync_out[2];

    // key layout as the host software expects it
    assign key_bits   = {sync_out[1], 1'b1, sync_out[0], 3'b111};
    assign controls_o = {2'b00, key_bits, ir_code_cnt_i, ir_code_i};

    // keys reach the controls word after the full chain
    a_controls_key_delay: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        $past(sys_reset_n, SYNC_STAGES) |->
            {controls_o[29], controls_o[27]} == $past(key_i, SYNC_STAGES)
    );

endmodule

// File: hw/osd_overlay_pipe.sv
`timescale 1ns/10ps

module osd_overlay_pipe (
    input  logic                      clk27,
    input  logic                      sys_reset_n,
    input  board_glue_pkg::pixel_t    pix_i,
    input  board_glue_pkg::vid_sync_t sync_i,
    input  board_glue_pkg::osd_req_t  osd_i,
    output board_glue_pkg::pixel_t    tx_pix_o,
    output board_glue_pkg::vid_sync_t tx_sync_o
);

    board_glue_pkg::pixel_t    osd_pix;
    board_glue_pkg::pixel_t    pix_s1;
    board_glue_pkg::vid_sync_t sync_s1;

    // ============================================================
    // palette lookup
    // ============================================================
    always_comb begin
        case (osd_i.color)
            2'd0: osd_pix = board_glue_pkg::osd_black;
            2'd1: osd_pix = board_glue_pkg::osd_blue;
            2'd2: osd_pix = board_glue_pkg::osd_yellow;
            default: osd_pix = board_glue_pkg::osd_white;
        endcase
    end

    // stage 1 substitution
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            pix_s1  <= '0;
            sync_s1 <= '0;
        end else begin
            pix_s1  <= osd_i.enable ? osd_pix : pix_i;
            sync_s1 <= sync_i;  // keep syncs aligned with pixel
        end
    end

    // stage 2 toward the transmitter
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            tx_pix_o  <= '0;
            tx_sync_o <= '0;
        end else begin
            tx_pix_o  <= pix_s1;
            tx_sync_o <= sync_s1;
        end
    end

    // an overlay request must show up as a palette color two cycles on
    a_osd_palette_out: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        osd_i.enable |-> ##2 (
            (tx_pix_o == board_glue_pkg::osd_black)  ||
            (tx_pix_o == board_glue_pkg::osd_blue)   ||
            (tx_pix_o == board_glue_pkg::osd_yellow) ||
            (tx_pix_o == board_glue_pkg::osd_white)
        )
    );

endmodule

// File: hw/resync_led_stretch.sv
`timescale 1ns/10ps

module resync_led_stretch #(
    parameter int SYNC_STAGES   = 2,
    parameter int LED_STRETCH_W = 24
) (
    input  logic clk27,
    input  logic sys_reset_n,
    input  logic resync_strobe_i,  // async
    output logic led_o
);

    logic [SYNC_STAGES-1:0]   strobe_sync_q;
    logic                     strobe_prev_q;
    logic                     strobe_rise;
    logic [LED_STRETCH_W-1:0] led_ctr_q;

    assign strobe_rise = strobe_sync_q[SYNC_STAGES-1] & ~strobe_prev_q;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            strobe_sync_q <= '0;
            strobe_prev_q <= 1'b0;
            led_ctr_q     <= '0;
        end else begin
            strobe_sync_q[0] <= resync_strobe_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                strobe_sync_q[i] <= strobe_sync_q[i-1];
            end
            strobe_prev_q <= strobe_sync_q[SYNC_STAGES-1];

            if (strobe_rise) begin
                led_ctr_q <= '1;  // retrigger while lit
            end else if (led_ctr_q != '0) begin
                led_ctr_q <= led_ctr_q - 1'b1;
            end
        end
    end

    assign led_o = (led_ctr_q != '0);

    a_ctr_only_reload_up: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        (led_ctr_q > $past(led_ctr_q)) |-> (&led_ctr_q)
    );

endmodule

// File: hw/board_glue_top.sv
`timescale 1ns/10ps

module board_glue_top #(
    parameter int SYNC_STAGES   = 2,
    parameter int LED_STRETCH_W = 24
) (
    input  logic                                   clk27,
    input  logic                                   sys_reset_n,
    input  logic [board_glue_pkg::ctrl_word_w-1:0] sys_ctrl_i,
    input  logic                                   isl_hsync_i,
    input  logic                                   isl_vsync_i,
    input  logic                                   isl_fid_i,
    input  logic [1:0]                             key_i,
    input  logic [board_glue_pkg::ir_code_w-1:0]   ir_code_i,
    input  logic [board_glue_pkg::ir_cnt_w-1:0]    ir_code_cnt_i,
    input  board_glue_pkg::pixel_t                 pix_i,
    input  board_glue_pkg::vid_sync_t              sync_i,
    input  board_glue_pkg::osd_req_t               osd_i,
    input  logic                                   resync_strobe_i,
    output logic [board_glue_pkg::ctrl_word_w-1:0] controls_o,
    output logic                                   vs_flag_o,
    output logic                                   hsync_o,
    output logic                                   vsync_o,
    output logic                                   fid_o,
    output board_glue_pkg::pixel_t                 tx_pix_o,
    output board_glue_pkg::vid_sync_t              tx_sync_o,
    output logic [7:0]                             led_o
);

    board_glue_pkg::ctrl_fields_t ctrl_fields;
    logic                         resync_led;

    // ============================================================
    // control and status
    // ============================================================
    sys_ctrl_decode u_ctrl (
        .clk27        (clk27),
        .sys_reset_n  (sys_reset_n),
        .sys_ctrl_i   (sys_ctrl_i),
        .ir_code_i    (ir_code_i),
        .vsync_i      (vsync_o),
        .resync_led_i (resync_led),
        .fields_o     (ctrl_fields),
        .vs_flag_o    (vs_flag_o),
        .led_o        (led_o)
    );

    digitizer_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .isl_hsync_i   (isl_hsync_i),
        .isl_vsync_i   (isl_vsync_i),
        .isl_fid_i     (isl_fid_i),
        .key_i         (key_i),
        .ir_code_i     (ir_code_i),
        .ir_code_cnt_i (ir_code_cnt_i),
        .hsync_pol_i   (ctrl_fields.hsync_pol),
        .vsync_pol_i   (ctrl_fields.vsync_pol),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .fid_o         (fid_o),
        .controls_o    (controls_o)
    );

    // ============================================================
    // pixel path and resync indicator
    // ============================================================
    osd_overlay_pipe u_osd (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .pix_i       (pix_i),
        .sync_i      (sync_i),
        .osd_i       (osd_i),
        .tx_pix_o    (tx_pix_o),
        .tx_sync_o   (tx_sync_o)
    );

    resync_led_stretch #(
        .SYNC_STAGES   (SYNC_STAGES),
        .LED_STRETCH_W (LED_STRETCH_W)
    ) u_resync (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .resync_strobe_i (resync_strobe_i),
        .led_o           (resync_led)
    );

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real period_ns    = 4.0,
    parameter int  reset_cycles = 5
) (
    output logic clk27_o,
    output logic sys_reset_n_o
);

    initial begin
        clk27_o = 1'b0;
        forever #(period_ns / 2.0) clk27_o = ~clk27_o;
    end

    // reset low from time 0, released on a falling edge
    initial begin
        sys_reset_n_o = 1'b0;
        repeat (reset_cycles) @(posedge clk27_o);
        @(negedge clk27_o);  // away from the sampling point
        sys_reset_n_o = 1'b1;
    end

endmodule

// File: bench/tb_board_glue.sv
`timescale 1ns/10ps

module tb_board_glue;

    localparam int sync_stages = 2;
    localparam int led_w       = 6;
    localparam int wait_limit  = 200;  // cycles allowed per wait loop

    logic                      clk27;
    logic                      sys_reset_n;
    logic [31:0]               sys_ctrl;
    logic                      isl_hsync;
    logic                      isl_vsync;
    logic                      isl_fid;
    logic [1:0]                key;
    logic [15:0]               ir_code;
    logic [7:0]                ir_cnt;
    board_glue_pkg::pixel_t    pix;
    board_glue_pkg::vid_sync_t sync_in;
    board_glue_pkg::osd_req_t  osd;
    logic                      resync_strobe;
    logic [31:0]               controls;
    logic                      vs_flag;
    logic                      hsync;
    logic                      vsync;
    logic                      fid;
    board_glue_pkg::pixel_t    tx_pix;
    board_glue_pkg::vid_sync_t tx_sync;
    logic [7:0]                led;

    int error_count;

    // expected pixel path contents, oldest first
    board_glue_pkg::pixel_t    exp_pix_q[$];
    board_glue_pkg::vid_sync_t exp_sync_q[$];

    tb_clk_gen clk_gen_i (
        .clk27_o       (clk27),
        .sys_reset_n_o (sys_reset_n)
    );

    board_glue_top #(
        .SYNC_STAGES   (sync_stages),
        .LED_STRETCH_W (led_w)
    ) dut_i (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .sys_ctrl_i      (sys_ctrl),
        .isl_hsync_i     (isl_hsync),
        .isl_vsync_i     (isl_vsync),
        .isl_fid_i       (isl_fid),
        .key_i           (key),
        .ir_code_i       (ir_code),
        .ir_code_cnt_i   (ir_cnt),
        .pix_i           (pix),
        .sync_i          (sync_in),
        .osd_i           (osd),
        .resync_strobe_i (resync_strobe),
        .controls_o      (controls),
        .vs_flag_o       (vs_flag),
        .hsync_o         (hsync),
        .vsync_o         (vsync),
        .fid_o           (fid),
        .tx_pix_o        (tx_pix),
        .tx_sync_o       (tx_sync),
        .led_o           (led)
    );

    // ============================================================
    // helpers
    // ============================================================
    // sample and drive point, 1 ns past the rising edge
    task automatic next_cycle();
        @(posedge clk27);
        #1;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    function automatic board_glue_pkg::pixel_t random_pixel();
        logic [31:0] r;
        r = $urandom;
        return r[23:0];
    endfunction

    function automatic board_glue_pkg::vid_sync_t random_sync();
        logic [31:0] r;
        r = $urandom;
        return r[2:0];
    endfunction

    task automatic wait_reset_release(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < wait_limit; n++) begin
            next_cycle();
            if (sys_reset_n) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("timeout: reset was never released");
            error_count++;
        end
    endtask

    // one pixel slot, checks the slot driven two cycles ago
    task automatic pipe_step(input board_glue_pkg::pixel_t p, input board_glue_pkg::vid_sync_t s,
                             input board_glue_pkg::osd_req_t o,
                             input board_glue_pkg::pixel_t exp_p);
        board_glue_pkg::pixel_t    old_p;
        board_glue_pkg::vid_sync_t old_s;
        next_cycle();
        if (exp_pix_q.size() == 2) begin
            old_p = exp_pix_q.pop_front();
            old_s = exp_sync_q.pop_front();
            check_value(32'(tx_pix), 32'(old_p), "tx_pix_o");
            check_value(32'(tx_sync), 32'(old_s), "tx_sync_o");
        end
        pix     = p;
        sync_in = s;
        osd     = o;
        exp_pix_q.push_back(exp_p);
        exp_sync_q.push_back(s);
    endtask

    task automatic pipe_flush();
        board_glue_pkg::osd_req_t idle;
        idle = '0;
        repeat (2) pipe_step('0, '0, idle, '0);
        exp_pix_q.delete();
        exp_sync_q.delete();
    endtask

    // ============================================================
    // test kinds
    // ============================================================
    task automatic run_reset_test(input logic [31:0] code, input logic [31:0] cnt,
                                  input logic [31:0] exp_ctl, input logic [31:0] exp_led,
                                  input logic [31:0] exp_flag, input logic [31:0] exp_pix,
                                  input logic [31:0] exp_sync);
        bit released;
        ir_code = code[15:0];
        ir_cnt  = cnt[7:0];
        wait_reset_release(released);
        if (released) begin
            check_value(controls, exp_ctl, "controls_o after reset");
            check_value(32'(led), exp_led, "led_o after reset");
            check_value(32'(vs_flag), exp_flag, "vs_flag_o after reset");
            check_value(32'(tx_pix), exp_pix, "tx_pix_o after reset");
            check_value(32'(tx_sync), exp_sync, "tx_sync_o after reset");
        end
    endtask

    task automatic run_overlay_test(input logic [31:0] color, input logic [31:0] exp_pix);
        board_glue_pkg::osd_req_t idle;
        board_glue_pkg::osd_req_t req;
        board_glue_pkg::pixel_t   p;
        idle       = '0;
        req.enable = 1'b1;
        req.color  = color[1:0];
        p = random_pixel();
        pipe_step(p, random_sync(), idle, p);   // filler before
        pipe_step(random_pixel(), random_sync(), req, exp_pix[23:0]);
        p = random_pixel();
        pipe_step(p, random_sync(), idle, p);   // filler after
        pipe_flush();
    endtask

    task automatic run_passthru_test(input logic [31:0] count);
        board_glue_pkg::osd_req_t req;
        board_glue_pkg::pixel_t   p;
        logic [31:0]              r;
        for (int n = 0; n < int'(count); n++) begin
            r          = $urandom;
            req.enable = 1'b0;
            req.color  = r[1:0];  // ignored while disabled
            p = random_pixel();
            pipe_step(p, random_sync(), req, p);
        end
        pipe_flush();
    endtask

    task automatic run_sync_test(input logic [31:0] ctrl, input logic [31:0] in_bits,
                                 input logic [31:0] exp_bits, input logic [31:0] exp_flag);
        sys_ctrl  = ctrl;
        isl_hsync = in_bits[2];
        isl_vsync = in_bits[1];
        isl_fid   = in_bits[0];
        repeat (sync_stages + 1) next_cycle();
        check_value(32'({hsync, vsync, fid}), exp_bits, "corrected syncs {h,v,fid}");
        check_value(32'(vs_flag), exp_flag, "vs_flag_o");
    endtask

    task automatic run_controls_test(input logic [31:0] ctrl, input logic [31:0] key_val,
                                     input logic [31:0] code, input logic [31:0] cnt,
                                     input logic [31:0] exp_ctl, input logic [31:0] exp_led);
        sys_ctrl = ctrl;
        key      = key_val[1:0];
        ir_code  = code[15:0];
        ir_cnt   = cnt[7:0];
        repeat (sync_stages + 1) next_cycle();
        check_value(controls, exp_ctl, "controls_o");
        check_value(32'(led), exp_led, "led_o");
    endtask

    task automatic run_resync_test(input logic [31:0] exp_delay, input logic [31:0] exp_lit,
                                   input logic [31:0] retrig);
        int delay;
        int lit;
        bit seen;
        bit fell;
        delay = 0;
        seen  = 1'b0;
        fell  = 1'b0;
        resync_strobe = 1'b1;
        for (int n = 0; n < wait_limit; n++) begin
            next_cycle();
            delay++;
            if (led[1]) begin
                seen = 1'b1;
                break;
            end
        end
        resync_strobe = 1'b0;
        if (!seen) begin
            $display("timeout: led 1 never lit after the resync strobe");
            error_count++;
        end else begin
            check_value(32'(delay), exp_delay, "cycles from strobe to led 1");
            lit = 1;
            for (int n = 0; n < wait_limit; n++) begin
                next_cycle();
                if (!led[1]) begin
                    fell = 1'b1;
                    break;
                end
                lit++;
                if (retrig != 0 && lit == retrig) resync_strobe = 1'b1;  // second strobe
                if (retrig != 0 && lit == retrig + 2) resync_strobe = 1'b0;
            end
            if (!fell) begin
                $display("timeout: led 1 stayed lit and never went dark");
                error_count++;
            end else begin
                check_value(32'(lit), exp_lit, "cycles led 1 stayed lit");
            end
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin : main
        int unsigned          seed_val;
        int                   fd;
        int                   n_read;
        int                   n_items;
        int                   kind;
        int                   test_num;
        int                   pass_count;
        int                   fail_count;
        int                   errors_before;
        logic [8*160-1:0]     line_buf;
        logic [31:0]          f0, f1, f2, f3, f4, f5, f6;

        error_count   = 0;
        test_num      = 0;
        pass_count    = 0;
        fail_count    = 0;
        sys_ctrl      = '0;
        isl_hsync     = 1'b0;
        isl_vsync     = 1'b0;
        isl_fid       = 1'b0;
        key           = 2'b11;  // released
        ir_code       = '0;
        ir_cnt        = '0;
        pix           = '0;
        sync_in       = '0;
        osd           = '0;
        resync_strobe = 1'b0;
        seed_val      = $urandom(32'h7c6e_fa7a);

        fd = $fopen("bench/board_glue_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file bench/board_glue_tests.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                n_read = $fgets(line_buf, fd);
                if (n_read == 0) break;
                n_items = $sscanf(line_buf, "%d %h %h %h %h %h %h %h",
                                  kind, f0, f1, f2, f3, f4, f5, f6);
                if (n_items == 8) begin  // comment and blank lines skipped
                    errors_before = error_count;
                    test_num++;
                    case (kind)
                        0: run_reset_test(f0, f1, f2, f3, f4, f5, f6);
                        1: run_overlay_test(f0, f1);
                        2: run_passthru_test(f0);
                        3: run_sync_test(f0, f1, f2, f3);
                        4: run_controls_test(f0, f1, f2, f3, f4, f5);
                        5: run_resync_test(f0, f1, f2);
                        default: begin
                            $display("test %0d has an unknown kind %0d", test_num, kind);
                            error_count++;
                        end
                    endcase
                    if (error_count == errors_before) begin
                        pass_count++;
                        $display("test %0d kind %0d passed", test_num, kind);
                    end else begin
                        fail_count++;
                        $display("test %0d kind %0d failed", test_num, kind);
                    end
                end
            end
            $fclose(fd);
            if (test_num == 0) begin
                $display("no tests were read from the tests file");
                error_count++;
            end
        end

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: bench/board_glue_tests.txt
# columns: kind (decimal) then f0..f6 (hex), unused fields 0
# 0 reset: ir_code ir_cnt exp_controls exp_led exp_vs_flag exp_tx_pix exp_tx_sync
# 1 overlay: color exp_pixel | 2 passthrough: pixel count
# 3 sync: ctrl {h,v,fid} exp_{h,v,fid} exp_vs_flag
# 4 controls: ctrl key ir_code ir_cnt exp_controls exp_led
# 5 resync: cycles to led 1, cycles lit, retrigger at lit cycle (0 none)
0 00a5 03 3f0300a5 00 0 000000 0
1 0 000000 0 0 0 0 0
1 1 0000ff 0 0 0 0 0
1 2 ffff00 0 0 0 0 0
1 3 ffffff 0 0 0 0 0
2 10 0 0 0 0 0 0
3 00000000 0 0 1 0 0 0
3 00000000 7 7 0 0 0 0
3 00000300 7 1 1 0 0 0
3 00000300 2 4 1 0 0 0
3 00000100 5 1 1 0 0 0
3 00001000 0 0 0 0 0 0
3 00001200 2 0 0 0 0 0
3 00000200 0 2 0 0 0 0
4 00004000 3 1234 05 3f051234 01 0
4 00000000 2 0000 00 37000000 80 0
4 00004000 1 0000 ff 1fff0000 81 0
4 0000c000 0 beef 7a 177abeef 01 0
4 00000000 3 8000 01 3f018000 00 0
5 3 3f 0 0 0 0 0
5 3 55 14 0 0 0 0

// File: src.f
hw/board_glue_pkg.sv
hw/sys_ctrl_decode.sv
hw/digitizer_sync.sv
hw/osd_overlay_pipe.sv
hw/resync_led_stretch.sv
hw/board_glue_top.sv
bench/tb_clk_gen.sv
bench/tb_board_glue.sv

// File: Makefile
# Verilator simulation of the board glue testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_board_glue \
		-f src.f -o sim_board_glue

run: compile
	./obj_dir/sim_board_glue | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
